// ==== pss_receiver.f ====
+incdir+source
source/pss_types_pkg.sv
source/pss_sequence_pkg.sv
source/pss_sample_window.sv
source/pss_correlator.sv
source/pss_peak_detector.sv
source/pss_receiver_top.sv
verification/pss_receiver_assert.sv
verification/pss_checker.sv
verification/pss_receiver_tb.sv

// ==== Bender.yml ====
package:
  name: pss_receiver

export_include_dirs:
  - source

sources:
  - source/pss_types_pkg.sv
  - source/pss_sequence_pkg.sv
  - source/pss_sample_window.sv
  - source/pss_correlator.sv
  - source/pss_peak_detector.sv
  - source/pss_receiver_top.sv
  - target: simulation
    files:
      - verification/pss_receiver_assert.sv
      - verification/pss_checker.sv
      - verification/pss_receiver_tb.sv

// ==== verification/pss_receiver_tb.sv ====
`default_nettype none

`include "pss_config.svh"

module pss_receiver_tb
    import pss_types_pkg::*, pss_sequence_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int STIM_CYCLES = 450;
    localparam int FLUSH_LEN   = 20;
    localparam int CHIP_AMP    = 64;
    localparam int MATCH_METRIC = `PSS_LEN * CHIP_AMP;
    // above the 11-chip partial match of a neighbouring sequence
    localparam metric_t SEQ_THRESHOLD   = 800;
    localparam metric_t NOISE_THRESHOLD = 4000;

    logic     clk;
    logic     reset_n;
    sample_t  sample;
    logic     sample_valid;
    metric_t  threshold;
    logic     detect;
    seq_idx_t n_id_2;
    metric_t  peak_metric;
    logic     done;
    int       expected_detections;
    int       errors;
    int       assert_errors;
    int       seed;

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic send_sample(input int i_val, input int q_val);
        @(posedge clk);
        sample_valid <= 1'b1;
        sample.i     <= `SAMPLE_DW'(i_val);
        sample.q     <= `SAMPLE_DW'(q_val);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        sample_valid <= 1'b0;
        sample       <= '0;
    endtask

    task automatic set_threshold(input metric_t value);
        @(posedge clk);
        sample_valid <= 1'b0;
        threshold    <= value;
    endtask

    // oldest chip first, so chip 0 ends up at age 0
    task automatic send_sequence(input int idx, input bit with_gaps);
        chips_t chips;
        int     gap;
        chips = pss_chips(seq_idx_t'(idx));
        for (int j = `PSS_LEN - 1; j >= 0; j--) begin
            if (with_gaps) begin
                gap = $random(seed) & 3;
                repeat (gap) begin
                    idle_cycle();
                end
            end
            send_sample(chips[j] ? CHIP_AMP : -CHIP_AMP, 0);
        end
    endtask

    // clears the window and outlasts the holdoff
    task automatic flush_window();
        repeat (FLUSH_LEN) begin
            send_sample(0, 0);
        end
    endtask

    initial begin
        seed                = 98;
        reset_n             = 1'b0;
        sample              = '0;
        sample_valid        = 1'b0;
        threshold           = SEQ_THRESHOLD;
        done                = 1'b0;
        expected_detections = 0;
        repeat (2) begin
            @(posedge clk);
        end
        reset_n <= 1'b1;
        repeat (5) begin
            idle_cycle();
        end

        // --------------------------------------------------
        // each local sequence on its own
        // --------------------------------------------------
        for (int s = 0; s < `NUM_SEQ; s++) begin
            send_sequence(s, 1'b0);
            flush_window();
            expected_detections++;
        end

        // small noise under a high threshold
        set_threshold(NOISE_THRESHOLD);
        repeat (48) begin
            send_sample($random(seed) % 9, $random(seed) % 9);
        end
        flush_window();
        set_threshold(SEQ_THRESHOLD);

        // --------------------------------------------------
        // holdoff, gaps and threshold edge
        // --------------------------------------------------
        send_sequence(1, 1'b0);
        send_sequence(1, 1'b0);
        flush_window();
        send_sequence(1, 1'b0);
        flush_window();
        expected_detections += 2;

        send_sequence(2, 1'b1);
        flush_window();
        expected_detections++;

        set_threshold(MATCH_METRIC);
        send_sequence(0, 1'b0);
        flush_window();
        set_threshold(MATCH_METRIC - 1);
        send_sequence(0, 1'b0);
        flush_window();
        expected_detections++;

        repeat (10) begin
            idle_cycle();
        end
        done <= 1'b1;
        repeat (2) begin
            @(posedge clk);
        end
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #((STIM_CYCLES + 100) * CLK_PERIOD);
        $display("timeout, the stimulus did not finish in time");
        $display("Regression failed");
        $finish;
    end

    pss_receiver_top i_pss_receiver_top (
        .clk_i          (clk),
        .reset_ni       (reset_n),
        .sample_i       (sample),
        .sample_valid_i (sample_valid),
        .threshold_i    (threshold),
        .detect_o       (detect),
        .n_id_2_o       (n_id_2),
        .peak_metric_o  (peak_metric)
    );

    assign assert_errors =
        i_pss_receiver_top.i_pss_peak_detector.i_pss_receiver_assert.fail_count;

    pss_checker i_pss_checker (
        .clk_i                 (clk),
        .reset_ni              (reset_n),
        .sample_i              (sample),
        .sample_valid_i        (sample_valid),
        .threshold_i           (threshold),
        .metrics_i             (i_pss_receiver_top.metrics),
        .metrics_valid_i       (i_pss_receiver_top.metric_valid[0]),
        .detect_i              (detect),
        .n_id_2_i              (n_id_2),
        .peak_metric_i         (peak_metric),
        .done_i                (done),
        .expected_detections_i (expected_detections),
        .assert_errors_i       (assert_errors),
        .errors_o              (errors)
    );

endmodule

`default_nettype wire

// ==== verification/pss_checker.sv ====
`default_nettype none

`include "pss_config.svh"

module pss_checker
    import pss_types_pkg::*;
(
    input  wire                     clk_i,
    input  wire                     reset_ni,
    input  wire sample_t            sample_i,
    input  wire                     sample_valid_i,
    input  wire metric_t            threshold_i,
    input  wire metric_t [`NUM_SEQ-1:0] metrics_i,
    input  wire                     metrics_valid_i,
    input  wire                     detect_i,
    input  wire seq_idx_t           n_id_2_i,
    input  wire metric_t            peak_metric_i,
    input  wire                     done_i,
    input  int                      expected_detections_i,
    input  int                      assert_errors_i,
    output int                      errors_o
);

    // metrics are seen 3 edges after capture, the decision 4 edges after
    localparam int DEPTH = 4;

    typedef struct packed {
        logic                   valid;
        logic                   det;
        seq_idx_t               idx;
        metric_t                peak;
        metric_t [`NUM_SEQ-1:0] metrics;
    } expect_t;

    logic [`PSS_LEN-1:0] ref_chips [`NUM_SEQ];
    int                  win_i [`PSS_LEN];
    int                  win_q [`PSS_LEN];
    expect_t             pipe [DEPTH];
    det_state_t          state;
    int                  hold_cnt;
    int                  value_errors = 0;
    int                  pulse_errors = 0;
    int                  detections = 0;

    assign errors_o = value_errors + pulse_errors + assert_errors_i;

    // NR PSS m-sequence, a chip is +1 where x is 0
    function automatic logic [`PSS_LEN-1:0] mseq_chips(input int shift);
        logic [63:0]         x;
        logic [`PSS_LEN-1:0] chips;
        x      = '0;
        x[6:0] = 7'b1110110;
        for (int n = 7; n < 64; n++) begin
            x[n] = x[n-3] ^ x[n-7];
        end
        for (int j = 0; j < `PSS_LEN; j++) begin
            chips[j] = ~x[j + shift];
        end
        return chips;
    endfunction

    // |re| + |im| of the model window against one sequence
    function automatic metric_t ref_metric(input int seq);
        int re;
        int im;
        re = 0;
        im = 0;
        for (int j = 0; j < `PSS_LEN; j++) begin
            if (ref_chips[seq][j]) begin
                re = re + win_i[j];
                im = im + win_q[j];
            end else begin
                re = re - win_i[j];
                im = im - win_q[j];
            end
        end
        if (re < 0) begin
            re = -re;
        end
        if (im < 0) begin
            im = -im;
        end
        return metric_t'(re + im);
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
        value_errors++;
        $display("ERROR time %0t: %s expected %0d, actual %0d", $time, name, exp_v, act_v);
    endtask

    initial begin
        for (int s = 0; s < `NUM_SEQ; s++) begin
            ref_chips[s] = mseq_chips(5 * s);
        end
    end

    // --------------------------------------------------
    // compare, then advance the model by one edge
    // --------------------------------------------------
    always @(posedge clk_i) begin : compare
        expect_t  cur;
        metric_t  best;
        seq_idx_t best_idx;
        if (!reset_ni) begin
            state    = SEARCH;
            hold_cnt = 0;
            for (int k = 0; k < DEPTH; k++) begin
                pipe[k] = '0;
            end
            for (int j = 0; j < `PSS_LEN; j++) begin
                win_i[j] = 0;
                win_q[j] = 0;
            end
        end else begin
            if (metrics_valid_i !== pipe[2].valid) begin
                pulse_errors++;
                $display("metric valid strobe out of step with the model at %0t", $time);
            end else if (pipe[2].valid) begin
                for (int t = 0; t < `NUM_SEQ; t++) begin
                    if (metrics_i[t] !== pipe[2].metrics[t]) begin
                        report_value($sformatf("metrics[%0d]", t), pipe[2].metrics[t],
                                     metrics_i[t]);
                    end
                end
            end
            if (detect_i !== pipe[3].det) begin
                pulse_errors++;
                if (pipe[3].det) begin
                    $display("missing detection pulse at %0t", $time);
                end else begin
                    $display("unexpected detection pulse at %0t", $time);
                end
            end
            if (n_id_2_i !== pipe[3].idx) begin
                report_value("n_id_2_o", pipe[3].idx, n_id_2_i);
            end
            if (peak_metric_i !== pipe[3].peak) begin
                report_value("peak_metric_o", pipe[3].peak, peak_metric_i);
            end
            if (detect_i === 1'b1) begin
                detections++;
            end

            // held outputs carry over until the next detection
            cur      = '0;
            cur.idx  = pipe[0].idx;
            cur.peak = pipe[0].peak;
            if (sample_valid_i) begin
                for (int j = `PSS_LEN - 1; j > 0; j--) begin
                    win_i[j] = win_i[j-1];
                    win_q[j] = win_q[j-1];
                end
                win_i[0]  = sample_i.i;
                win_q[0]  = sample_i.q;
                cur.valid = 1'b1;
                best_idx  = '0;
                for (int t = 0; t < `NUM_SEQ; t++) begin
                    cur.metrics[t] = ref_metric(t);
                end
                best = cur.metrics[0];
                for (int t = 1; t < `NUM_SEQ; t++) begin
                    if (cur.metrics[t] > best) begin
                        best     = cur.metrics[t];
                        best_idx = seq_idx_t'(t);
                    end
                end
                if (state == SEARCH) begin
                    if (best > threshold_i) begin
                        cur.det  = 1'b1;
                        cur.idx  = best_idx;
                        cur.peak = best;
                        state    = HOLD;
                        hold_cnt = 0;
                    end
                end else if (hold_cnt == `HOLDOFF_SAMPLES - 1) begin
                    state = SEARCH;
                end else begin
                    hold_cnt++;
                end
            end
            for (int k = DEPTH - 1; k > 0; k--) begin
                pipe[k] = pipe[k-1];
            end
            pipe[0] = cur;
        end
    end

    always @(posedge done_i) begin
        if (detections != expected_detections_i) begin
            pulse_errors++;
            $display("saw %0d detection pulses where %0d were expected", detections,
                     expected_detections_i);
        end
        $display("checks done: %0d value errors, %0d pulse errors, %0d assertion errors",
                 value_errors, pulse_errors, assert_errors_i);
    end

endmodule

`default_nettype wire

// ==== verification/pss_receiver_assert.sv ====
`default_nettype none

`include "pss_config.svh"

module pss_receiver_assert
    import pss_types_pkg::*;
(
    input wire           clk_i,
    input wire           reset_ni,
    input wire           detect_i,
    input wire seq_idx_t n_id_2_i
);

    // number of failed assertions
    int fail_count = 0;

    // a detection is a single-cycle pulse
    single_pulse: assert property (@(posedge clk_i) disable iff (!reset_ni)
        detect_i |=> !detect_i)
        else begin
            fail_count++;
            $error("detect_o high on two consecutive cycles");
        end

    idx_range: assert property (@(posedge clk_i) disable iff (!reset_ni)
        n_id_2_i < `NUM_SEQ)
        else begin
            fail_count++;
            $error("n_id_2_o out of range");
        end

    quiet_in_reset: assert property (@(posedge clk_i) !reset_ni |=> !detect_i)
        else begin
            fail_count++;
            $error("detect_o high during reset");
        end

endmodule

bind pss_peak_detector pss_receiver_assert i_pss_receiver_assert (
    .clk_i    (clk_i),
    .reset_ni (reset_ni),
    .detect_i (detect_o),
    .n_id_2_i (n_id_2_o)
);

`default_nettype wire

// ==== source/pss_receiver_top.sv ====
`default_nettype none

`include "pss_config.svh"

module pss_receiver_top
    import pss_types_pkg::*;
(
    input  wire       clk_i,
    input  wire       reset_ni,

    input  wire       sample_t sample_i,
    input  wire       sample_valid_i,
    input  wire       metric_t threshold_i,

    output logic      detect_o,
    output seq_idx_t  n_id_2_o,
    output metric_t   peak_metric_o
);

    window_t                  window;
    logic                     window_valid;
    metric_t [`NUM_SEQ-1:0]   metrics;
    logic    [`NUM_SEQ-1:0]   metric_valid;

    // --------------------------------------------------
    // shared sample window
    // --------------------------------------------------
    pss_sample_window i_pss_sample_window (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .window_o       (window),
        .window_valid_o (window_valid)
    );

    // one correlator per N_id_2
    for (genvar g = 0; g < `NUM_SEQ; g++) begin : g_corr
        pss_correlator #(
            .SEQ_IDX (g)
        ) i_pss_correlator (
            .clk_i          (clk_i),
            .reset_ni       (reset_ni),
            .window_i       (window),
            .window_valid_i (window_valid),
            .metric_o       (metrics[g]),
            .metric_valid_o (metric_valid[g])
        );
    end

    // --------------------------------------------------
    // peak detector
    // --------------------------------------------------
    // all correlators share one latency
    pss_peak_detector i_pss_peak_detector (
        .clk_i           (clk_i),
        .reset_ni        (reset_ni),
        .metrics_i       (metrics),
        .metrics_valid_i (metric_valid[0]),
        .threshold_i     (threshold_i),
        .detect_o        (detect_o),
        .n_id_2_o        (n_id_2_o),
        .peak_metric_o   (peak_metric_o)
    );

endmodule

`default_nettype wire

// ==== source/pss_peak_detector.sv ====
`default_nettype none

`include "pss_config.svh"

module pss_peak_detector
    import pss_types_pkg::*;
(
    input  wire       clk_i,
    input  wire       reset_ni,

    input  wire       metric_t [`NUM_SEQ-1:0] metrics_i,
    input  wire       metrics_valid_i,
    input  wire       metric_t threshold_i,

    output logic      detect_o,
    output seq_idx_t  n_id_2_o,
    output metric_t   peak_metric_o
);

    localparam int CNT_DW = $clog2(`HOLDOFF_SAMPLES);

    det_state_t         state_q;
    logic [CNT_DW-1:0]  hold_cnt_q;
    seq_idx_t           best_idx;
    metric_t            best_metric;
    logic               above;

    // --------------------------------------------------
    // strongest correlator, ties to the lowest index
    // --------------------------------------------------
    always_comb begin
        best_idx    = '0;
        best_metric = metrics_i[0];
        for (int i = 1; i < `NUM_SEQ; i++) begin
            if (metrics_i[i] > best_metric) begin
                best_idx    = seq_idx_t'(i);
                best_metric = metrics_i[i];
            end
        end
    end

    // strictly greater
    assign above = best_metric > threshold_i;

    // --------------------------------------------------
    // search / holdoff FSM
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q       <= SEARCH;
            hold_cnt_q    <= '0;
            detect_o      <= 1'b0;
            n_id_2_o      <= '0;
            peak_metric_o <= '0;
        end else begin
            detect_o <= 1'b0;
            case (state_q)
                SEARCH: begin
                    if (metrics_valid_i && above) begin
                        detect_o      <= 1'b1;
                        n_id_2_o      <= best_idx;
                        peak_metric_o <= best_metric;
                        hold_cnt_q    <= '0;
                        state_q       <= HOLD;
                    end
                end
                HOLD: begin
                    // count valid metrics only, gaps do not shorten the holdoff
                    if (metrics_valid_i) begin
                        if (hold_cnt_q == CNT_DW'(`HOLDOFF_SAMPLES - 1)) begin
                            state_q <= SEARCH;
                        end else begin
                            hold_cnt_q <= hold_cnt_q + 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= SEARCH;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/pss_correlator.sv ====
`default_nettype none

`include "pss_config.svh"

module pss_correlator
    import pss_types_pkg::*, pss_sequence_pkg::*;
#(
    parameter int SEQ_IDX = 0
)
(
    input  wire      clk_i,
    input  wire      reset_ni,

    input  wire      window_t window_i,
    input  wire      window_valid_i,

    output metric_t  metric_o,
    output logic     metric_valid_o
);

    localparam chips_t CHIPS = pss_chips(seq_idx_t'(SEQ_IDX));

    corr_sum_t re_sum;
    corr_sum_t im_sum;
    corr_sum_t re_q;
    corr_sum_t im_q;
    logic      sum_valid_q;

    // widen before negating so that the most negative sum survives
    function automatic metric_t abs_sum(corr_sum_t value);
        logic signed [`METRIC_DW-1:0] ext;
        ext = value;
        return metric_t'(ext[`METRIC_DW-1] ? -ext : ext);
    endfunction

    // --------------------------------------------------
    // stage 1: signed sums against the chips
    // --------------------------------------------------
    always_comb begin
        re_sum = '0;
        im_sum = '0;
        for (int j = 0; j < `PSS_LEN; j++) begin
            if (CHIPS[j]) begin
                re_sum = re_sum + window_i[j].i;
                im_sum = im_sum + window_i[j].q;
            end else begin
                re_sum = re_sum - window_i[j].i;
                im_sum = im_sum - window_i[j].q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        re_q <= re_sum;
        im_q <= im_sum;
    end

    // --------------------------------------------------
    // stage 2: |re| + |im|
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        metric_o <= abs_sum(re_q) + abs_sum(im_q);
    end

    // valids travel with the data
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sum_valid_q    <= 1'b0;
            metric_valid_o <= 1'b0;
        end else begin
            sum_valid_q    <= window_valid_i;
            metric_valid_o <= sum_valid_q;
        end
    end

endmodule

`default_nettype wire

// ==== source/pss_sample_window.sv ====
`default_nettype none

`include "pss_config.svh"

module pss_sample_window
    import pss_types_pkg::*;
(
    input  wire      clk_i,
    input  wire      reset_ni,

    input  wire      sample_t sample_i,
    input  wire      sample_valid_i,

    output window_t  window_o,
    output logic     window_valid_o
);

    // --------------------------------------------------
    // shift register, newest sample at position 0
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            window_o <= '0;
        end else if (sample_valid_i) begin
            window_o <= {window_o[`PSS_LEN-2:0], sample_i};
        end
    end

    // one strobe per accepted sample
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            window_valid_o <= 1'b0;
        end else begin
            window_valid_o <= sample_valid_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/pss_sequence_pkg.sv ====
`default_nettype none

`include "pss_config.svh"

package pss_sequence_pkg;

    import pss_types_pkg::*;

    // bit j set means +1 at sample age j, clear means -1
    typedef logic [`PSS_LEN-1:0] chips_t;

    // --------------------------------------------------
    // first chips of the NR PSS m-sequence
    // --------------------------------------------------
    // x(i+7) = x(i+4) ^ x(i), seed 1110110, d = 1 - 2x
    // entries are shifted by 0, 5 and 10 chips
    localparam chips_t PSS_CHIPS [`NUM_SEQ] = '{
        16'h6309,
        16'h2B18,
        16'h9958
    };

    function automatic chips_t pss_chips(seq_idx_t idx);
        chips_t chips;
        chips = PSS_CHIPS[0];
        // out of range index falls back to sequence 0
        if (int'(idx) < `NUM_SEQ) begin
            chips = PSS_CHIPS[idx];
        end
        return chips;
    endfunction

endpackage

`default_nettype wire

// ==== source/pss_types_pkg.sv ====
`default_nettype none

`include "pss_config.svh"

package pss_types_pkg;

    // one complex baseband sample
    typedef struct packed {
        logic signed [`SAMPLE_DW-1:0] i;
        logic signed [`SAMPLE_DW-1:0] q;
    } sample_t;

    // element 0 is the newest sample
    typedef sample_t [`PSS_LEN-1:0] window_t;

    // signed correlation sum over the window
    localparam int SUM_DW = `SAMPLE_DW + $clog2(`PSS_LEN);
    typedef logic signed [SUM_DW-1:0] corr_sum_t;

    typedef logic [`METRIC_DW-1:0] metric_t;

    // index of a local sequence, also N_id_2
    typedef logic [1:0] seq_idx_t;

    typedef enum logic {
        SEARCH,
        HOLD
    } det_state_t;

endpackage

`default_nettype wire

// ==== source/pss_config.svh ====
`ifndef PSS_CONFIG_SVH
`define PSS_CONFIG_SVH

// --------------------------------------------------
// sync sequence and sample format
// --------------------------------------------------

// chips per sequence, also the window depth
`define PSS_LEN 16

// signed width of I and of Q
`define SAMPLE_DW 8

// one local sequence per N_id_2
`define NUM_SEQ 3

// --------------------------------------------------
// detector
// --------------------------------------------------

// valid samples ignored after a detection
`define HOLDOFF_SAMPLES 16

// |re| + |im| of two full-scale sums
`define METRIC_DW 13

`endif
